// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_csr_file
FLIST     := flist.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "TEST PASSED" $(SIM_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)

// ==== csr_file.sv ====
module csr_file
#(
    parameter csr_pkg::csr_word_t HART_ID = 32'd0
)
(
    input  logic               clk_i,
    input  logic               rst_i,

    // CSR read and write
    input  csr_pkg::csr_addr_t csr_raddr_i,
    output csr_pkg::csr_word_t csr_rdata_o,
    input  csr_pkg::csr_wr_t   csr_wr_i,

    // Interrupt levels and trap outputs
    input  logic               ext_irq_i,
    input  logic               tmr_irq_i,
    input  logic               sft_irq_i,
    input  trap_pkg::xcpt_t    xcpt_i,
    input  csr_pkg::csr_word_t nxt_pc_i,
    output logic               irq_taken_o,
    output csr_pkg::csr_word_t pc_handler_o,

    // System jump
    input  logic               sys_jump_i,
    input  logic               mret_i,
    output logic               sys_jump_o,
    output csr_pkg::csr_word_t sys_jump_pc_o,

    output trap_pkg::priv_e    priv_o
);

    import csr_pkg::*;
    import trap_pkg::*;

    // ------------------------------------------------------------------------
    // Peer connections
    // ------------------------------------------------------------------------

    csr_word_t   mie_w;
    csr_word_t   mip_w;
    csr_word_t   mtvec_w;
    csr_word_t   mtval_w;
    trap_state_t trap_state_w;
    logic [63:0] cycles_w;

    cycle_counter cycle_counter_i
    (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .csr_wr_i (csr_wr_i),
        .cycles_o (cycles_w)
    );

    csr_regs
    #(
        .HART_ID (HART_ID)
    )
    csr_regs_i
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .csr_wr_i     (csr_wr_i),
        .csr_raddr_i  (csr_raddr_i),
        .ext_irq_i    (ext_irq_i),
        .tmr_irq_i    (tmr_irq_i),
        .sft_irq_i    (sft_irq_i),
        .trap_state_i (trap_state_w),
        .mtval_i      (mtval_w),
        .cycles_i     (cycles_w),
        .mie_o        (mie_w),
        .mip_o        (mip_w),
        .mtvec_o      (mtvec_w),
        .csr_rdata_o  (csr_rdata_o)
    );

    trap_ctrl trap_ctrl_i
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .csr_wr_i      (csr_wr_i),
        .xcpt_i        (xcpt_i),
        .mie_i         (mie_w),
        .mip_i         (mip_w),
        .mtvec_i       (mtvec_w),
        .nxt_pc_i      (nxt_pc_i),
        .sys_jump_i    (sys_jump_i),
        .mret_i        (mret_i),
        .irq_taken_o   (irq_taken_o),
        .pc_handler_o  (pc_handler_o),
        .sys_jump_o    (sys_jump_o),
        .sys_jump_pc_o (sys_jump_pc_o),
        .trap_state_o  (trap_state_w),
        .mtval_o       (mtval_w),
        .priv_o        (priv_o)
    );

endmodule

// ==== csr_file_checker.sv ====
module csr_file_checker
(
    input logic               clk_i,
    input logic               rst_i,
    input logic               irq_taken_i,
    input csr_pkg::csr_word_t pc_handler_i,
    input trap_pkg::priv_e    priv_i,
    input logic               sys_jump_in_i,
    input logic               sys_jump_out_i
);

    import trap_pkg::*;

    // Failed assertion count
    int unsigned fail_count = 0;

    // ------------------------------------------------------------------------
    // Trap and jump outputs
    // ------------------------------------------------------------------------

    // Handler addresses stay word aligned, in vectored mode too
    handler_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        irq_taken_i |-> (pc_handler_i[1:0] == 2'b00))
    else
    begin
        fail_count = fail_count + 1;
        $error("pc_handler_o is not word aligned while a trap is taken");
    end

    // Only user and machine levels exist
    priv_legal: assert property (@(posedge clk_i) disable iff (rst_i)
        (priv_i == PRIV_M) || (priv_i == PRIV_U))
    else
    begin
        fail_count = fail_count + 1;
        $error("priv_o holds a level other than machine or user");
    end

    // Jump strobe passes straight through
    jump_passthru: assert property (@(posedge clk_i) disable iff (rst_i)
        sys_jump_out_i == sys_jump_in_i)
    else
    begin
        fail_count = fail_count + 1;
        $error("sys_jump_o does not follow sys_jump_i");
    end

endmodule

bind csr_file csr_file_checker checker_i
(
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .irq_taken_i    (irq_taken_o),
    .pc_handler_i   (pc_handler_o),
    .priv_i         (priv_o),
    .sys_jump_in_i  (sys_jump_i),
    .sys_jump_out_i (sys_jump_o)
);

// ==== csr_pkg.sv ====
package csr_pkg;

    // ------------------------------------------------------------------------
    // Basic CSR types
    // ------------------------------------------------------------------------

    // 12-bit CSR address as encoded in the instruction
    typedef logic [11:0] csr_addr_t;

    // One 32-bit register word
    typedef logic [31:0] csr_word_t;

    // ------------------------------------------------------------------------
    // Machine-level CSR addresses
    // ------------------------------------------------------------------------

    // Trap setup
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;

    // Trap handling
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MIP       = 12'h344;

    // Machine cycle counter, low and high words
    localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;

    // User read-only aliases of the cycle counter
    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_CYCLEH    = 12'hC80;

    // Read-only ID registers
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // ------------------------------------------------------------------------
    // Write request from the writeback stage
    // ------------------------------------------------------------------------

    // Each block decodes its own addresses out of this request
    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        csr_word_t data;
    } csr_wr_t;

endpackage

// ==== csr_regs.sv ====
module csr_regs
#(
    parameter csr_pkg::csr_word_t HART_ID = 32'd0
)
(
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Write request and read address
    input  csr_pkg::csr_wr_t     csr_wr_i,
    input  csr_pkg::csr_addr_t   csr_raddr_i,

    // Interrupt levels
    input  logic                 ext_irq_i,
    input  logic                 tmr_irq_i,
    input  logic                 sft_irq_i,

    // Registers kept elsewhere, for reads only
    input  trap_pkg::trap_state_t trap_state_i,
    input  csr_pkg::csr_word_t   mtval_i,
    input  logic [63:0]          cycles_i,

    // Interrupt setup towards the trap controller
    output csr_pkg::csr_word_t   mie_o,
    output csr_pkg::csr_word_t   mip_o,
    output csr_pkg::csr_word_t   mtvec_o,

    output csr_pkg::csr_word_t   csr_rdata_o
);

    import csr_pkg::*;

    csr_word_t mie_q;
    csr_word_t mip_q;
    csr_word_t mtvec_q;
    csr_word_t mscratch_q;

    // Raw lines placed at their mip bit positions
    csr_word_t irq_lines;

    // ------------------------------------------------------------------------
    // Writable registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end
        else if (csr_wr_i.we)
        begin
            case (csr_wr_i.addr)
                CSR_MIE:      mie_q      <= csr_wr_i.data;
                CSR_MTVEC:    mtvec_q    <= csr_wr_i.data;
                CSR_MSCRATCH: mscratch_q <= csr_wr_i.data;
                default:      ;
            endcase
        end
    end

    // External on bit 11, timer on bit 7, software on bit 3
    assign irq_lines = {20'd0, ext_irq_i, 3'd0, tmr_irq_i, 3'd0, sft_irq_i, 3'd0};

    // mip follows the enabled lines with one cycle of latency
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mip_q <= '0;
        end
        else
        begin
            mip_q <= irq_lines & mie_q;
        end
    end

    assign mie_o   = mie_q;
    assign mip_o   = mip_q;
    assign mtvec_o = mtvec_q;

    // ------------------------------------------------------------------------
    // Read multiplexer
    // ------------------------------------------------------------------------

    // Combinational, unknown addresses read zero
    always_comb
    begin
        case (csr_raddr_i)
            CSR_MSTATUS:   csr_rdata_o = trap_state_i.status.raw;
            CSR_MIE:       csr_rdata_o = mie_q;
            CSR_MTVEC:     csr_rdata_o = mtvec_q;
            CSR_MSCRATCH:  csr_rdata_o = mscratch_q;
            CSR_MEPC:      csr_rdata_o = trap_state_i.mepc;
            CSR_MCAUSE:    csr_rdata_o = trap_state_i.mcause;
            CSR_MTVAL:     csr_rdata_o = mtval_i;
            CSR_MIP:       csr_rdata_o = mip_q;
            // User aliases read the same counter
            CSR_MCYCLE,
            CSR_CYCLE:     csr_rdata_o = cycles_i[31:0];
            CSR_MCYCLEH,
            CSR_CYCLEH:    csr_rdata_o = cycles_i[63:32];
            // Non-commercial core, vendor and implementation IDs are zero
            CSR_MVENDORID: csr_rdata_o = '0;
            CSR_MARCHID:   csr_rdata_o = '0;
            CSR_MIMPID:    csr_rdata_o = '0;
            CSR_MHARTID:   csr_rdata_o = HART_ID;
            default:       csr_rdata_o = '0;
        endcase
    end

endmodule

// ==== cycle_counter.sv ====
module cycle_counter
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  csr_pkg::csr_wr_t csr_wr_i,
    output logic [63:0]      cycles_o
);

    import csr_pkg::*;

    logic [63:0] count_q;

    // Only the machine addresses are writable
    // cycle and cycleh are read aliases and ignore writes
    logic wr_lo;
    logic wr_hi;

    assign wr_lo = csr_wr_i.we && (csr_wr_i.addr == CSR_MCYCLE);
    assign wr_hi = csr_wr_i.we && (csr_wr_i.addr == CSR_MCYCLEH);

    // ------------------------------------------------------------------------
    // Counter
    // ------------------------------------------------------------------------

    // A written word holds for one cycle before counting resumes
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            count_q <= 64'd0;
        end
        else if (wr_lo)
        begin
            count_q[31:0] <= csr_wr_i.data;
        end
        else if (wr_hi)
        begin
            count_q[63:32] <= csr_wr_i.data;
        end
        else
        begin
            count_q <= count_q + 64'd1;
        end
    end

    assign cycles_o = count_q;

endmodule

// ==== flist.f ====
csr_pkg.sv
trap_pkg.sv
cycle_counter.sv
csr_regs.sv
trap_ctrl.sv
csr_file.sv
csr_file_checker.sv
tb_csr_file.sv

// ==== tb_csr_file.sv ====
module tb_csr_file;

    import csr_pkg::*;
    import trap_pkg::*;

    localparam int        CLK_PERIOD   = 8;
    localparam int        RESET_CYCLES = 8;
    localparam int        RANDOM_SEED  = 34;
    localparam csr_word_t HART_ID      = 32'd5;

    // Cycle budget per test in run order, plus slack
    localparam int TEST_CYCLES = 4 + 12 + 10 + 8 + 16 + 20;
    localparam int MARGIN      = 30;

    logic      clk_i;
    logic      rst_i;
    csr_addr_t csr_raddr_i;
    csr_word_t csr_rdata_o;
    csr_wr_t   csr_wr_i;
    logic      ext_irq_i;
    logic      tmr_irq_i;
    logic      sft_irq_i;
    xcpt_t     xcpt_i;
    csr_word_t nxt_pc_i;
    logic      irq_taken_o;
    csr_word_t pc_handler_o;
    logic      sys_jump_i;
    logic      mret_i;
    logic      sys_jump_o;
    csr_word_t sys_jump_pc_o;
    priv_e     priv_o;

    // State carried from one test to the next
    csr_word_t handler_base;
    csr_word_t saved_pc;

    csr_file
    #(
        .HART_ID (HART_ID)
    )
    dut_i
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .csr_raddr_i   (csr_raddr_i),
        .csr_rdata_o   (csr_rdata_o),
        .csr_wr_i      (csr_wr_i),
        .ext_irq_i     (ext_irq_i),
        .tmr_irq_i     (tmr_irq_i),
        .sft_irq_i     (sft_irq_i),
        .xcpt_i        (xcpt_i),
        .nxt_pc_i      (nxt_pc_i),
        .irq_taken_o   (irq_taken_o),
        .pc_handler_o  (pc_handler_o),
        .sys_jump_i    (sys_jump_i),
        .mret_i        (mret_i),
        .sys_jump_o    (sys_jump_o),
        .sys_jump_pc_o (sys_jump_pc_o),
        .priv_o        (priv_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Drive and compare helpers
    // ------------------------------------------------------------------------

    // Inputs change one time unit after the rising edge
    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_priv(input string name, input priv_e got, input priv_e exp);
        if (got !== exp)
        begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // One write request, captured at the next edge
    task automatic write_csr(input csr_addr_t addr, input csr_word_t data);
        csr_wr_i = '{we: 1'b1, addr: addr, data: data};
        tick();
        csr_wr_i.we = 1'b0;
    endtask

    // Combinational read, settles within one time unit
    task automatic read_csr(input csr_addr_t addr, output csr_word_t data);
        csr_raddr_i = addr;
        #1;
        data = csr_rdata_o;
    endtask

    task automatic expect_csr(input string name, input csr_addr_t addr, input csr_word_t exp);
        csr_word_t got;
        read_csr(addr, got);
        check_word(name, got, exp);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_values();
        // MPP machine and MIE set
        expect_csr("mstatus", CSR_MSTATUS, 32'h0000_1808);
        expect_csr("mhartid", CSR_MHARTID, HART_ID);
        expect_csr("mvendorid", CSR_MVENDORID, 32'd0);
        tick();
        expect_csr("marchid", CSR_MARCHID, 32'd0);
        expect_csr("mimpid", CSR_MIMPID, 32'd0);
        expect_csr("unmapped csr", 12'h7C0, 32'd0);
        check_priv("priv_o", priv_o, PRIV_M);
        tick();
    endtask

    task automatic test_write_readback();
        csr_word_t scratch_val;
        csr_word_t mtvec_val;
        csr_word_t mie_val;
        scratch_val = $urandom();
        mtvec_val   = $urandom();
        mie_val     = $urandom();
        // MIE clear so the timer line below does not trap
        write_csr(CSR_MSTATUS, 32'h0000_1800);
        write_csr(CSR_MSCRATCH, scratch_val);
        expect_csr("mscratch", CSR_MSCRATCH, scratch_val);
        write_csr(CSR_MTVEC, mtvec_val);
        expect_csr("mtvec", CSR_MTVEC, mtvec_val);
        write_csr(CSR_MIE, mie_val);
        expect_csr("mie", CSR_MIE, mie_val);
        write_csr(CSR_MIE, 32'hFFFF_FFFF);
        tmr_irq_i = 1'b1;
        // One cycle of latency on mip
        expect_csr("mip", CSR_MIP, 32'd0);
        tick();
        expect_csr("mip", CSR_MIP, 32'h0000_0080);
        tmr_irq_i = 1'b0;
        tick();
    endtask

    task automatic test_vectored_irq();
        csr_word_t ret_pc;
        handler_base = $urandom() & 32'hFFFF_FF00;
        ret_pc       = $urandom() & 32'hFFFF_FFFC;
        // Vectored mode
        write_csr(CSR_MTVEC, handler_base | 32'd1);
        ext_irq_i = 1'b1;
        tmr_irq_i = 1'b1;
        write_csr(CSR_MSTATUS, 32'h0000_1808);
        ext_irq_i = 1'b0;
        tmr_irq_i = 1'b0;
        nxt_pc_i  = ret_pc;
        #1;
        // External wins, cause 11 at four bytes per entry
        check_bit("irq_taken_o", irq_taken_o, 1'b1);
        check_word("pc_handler_o", pc_handler_o, handler_base + 32'd44);
        tick();
        expect_csr("mcause", CSR_MCAUSE, 32'h8000_000B);
        expect_csr("mepc", CSR_MEPC, ret_pc);
        // MPP machine, MPIE set, MIE clear
        expect_csr("mstatus", CSR_MSTATUS, 32'h0000_1880);
        check_bit("irq_taken_o", irq_taken_o, 1'b0);
        tick();
    endtask

    task automatic test_exceptions();
        csr_word_t tval;
        csr_word_t pc_a;
        csr_word_t pc_b;
        tval = $urandom();
        pc_a = $urandom() & 32'hFFFF_FFFC;
        pc_b = $urandom() & 32'hFFFF_FFFC;
        xcpt_i   = '{valid: 1'b1, cause: 4'd5, tval: tval};
        nxt_pc_i = pc_a;
        #1;
        // Exceptions use the base even in vectored mode
        check_bit("irq_taken_o", irq_taken_o, 1'b1);
        check_word("pc_handler_o", pc_handler_o, handler_base);
        tick();
        xcpt_i.valid = 1'b0;
        expect_csr("mcause", CSR_MCAUSE, 32'd5);
        expect_csr("mtval", CSR_MTVAL, tval);
        expect_csr("mepc", CSR_MEPC, pc_a);
        // Cause 2 carries no trap value
        xcpt_i   = '{valid: 1'b1, cause: 4'd2, tval: ~tval};
        nxt_pc_i = pc_b;
        #1;
        check_word("pc_handler_o", pc_handler_o, handler_base);
        tick();
        xcpt_i.valid = 1'b0;
        expect_csr("mcause", CSR_MCAUSE, 32'd2);
        expect_csr("mtval", CSR_MTVAL, tval);
        expect_csr("mepc", CSR_MEPC, pc_b);
        saved_pc = pc_b;
        tick();
    endtask

    task automatic test_mret_user();
        // MPP machine, MPIE set, MIE clear
        write_csr(CSR_MSTATUS, 32'h0000_1880);
        sys_jump_i = 1'b1;
        mret_i     = 1'b1;
        #1;
        check_bit("sys_jump_o", sys_jump_o, 1'b1);
        check_word("sys_jump_pc_o", sys_jump_pc_o, saved_pc);
        tick();
        sys_jump_i = 1'b0;
        mret_i     = 1'b0;
        // MIE back from MPIE, MPIE set again
        expect_csr("mstatus", CSR_MSTATUS, 32'h0000_1888);
        check_priv("priv_o", priv_o, PRIV_M);
        // MPP user
        write_csr(CSR_MSTATUS, 32'h0000_0080);
        // mret level without the jump strobe changes nothing
        mret_i = 1'b1;
        tick();
        check_priv("priv_o", priv_o, PRIV_M);
        sys_jump_i = 1'b1;
        tick();
        sys_jump_i = 1'b0;
        mret_i     = 1'b0;
        #1;
        check_priv("priv_o", priv_o, PRIV_U);
        expect_csr("mstatus", CSR_MSTATUS, 32'h0000_0088);
        // Enabled and pending, yet ignored in user mode
        ext_irq_i = 1'b1;
        repeat (3)
        begin
            tick();
            check_bit("irq_taken_o", irq_taken_o, 1'b0);
        end
        expect_csr("mip", CSR_MIP, 32'h0000_0800);
        ext_irq_i = 1'b0;
        tick();
    endtask

    task automatic test_cycle_counter();
        csr_word_t start_val;
        csr_word_t first;
        csr_word_t second;
        start_val = $urandom();
        write_csr(CSR_MCYCLE, start_val);
        // Third cycle after the write edge
        tick();
        tick();
        read_csr(CSR_MCYCLE, first);
        check_word("mcycle", first, start_val + 32'd2);
        expect_csr("cycle", CSR_CYCLE, first);
        repeat (10) tick();
        read_csr(CSR_MCYCLE, second);
        check_word("mcycle delta", second - first, 32'd10);
        // User alias is read-only, the count keeps running
        write_csr(CSR_CYCLE, 32'd0);
        expect_csr("mcycle", CSR_MCYCLE, second + 32'd1);
        tick();
    endtask

    // ------------------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------------------

    initial
    begin
        void'($urandom(RANDOM_SEED));
        rst_i       = 1'b1;
        csr_raddr_i = '0;
        csr_wr_i    = '0;
        ext_irq_i   = 1'b0;
        tmr_irq_i   = 1'b0;
        sft_irq_i   = 1'b0;
        xcpt_i      = '0;
        nxt_pc_i    = '0;
        sys_jump_i  = 1'b0;
        mret_i      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        test_reset_values();
        test_write_readback();
        test_vectored_irq();
        test_exceptions();
        test_mret_user();
        test_cycle_counter();
        if (dut_i.checker_i.fail_count == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("TEST FAILED");
            $fatal(1, "Bound assertions failed during the run");
        end
    end

    // Watchdog
    initial
    begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $fatal(1, "Simulation timed out");
    end

endmodule

// ==== trap_ctrl.sv ====
module trap_ctrl
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  csr_pkg::csr_wr_t      csr_wr_i,

    // Exception request from the pipeline
    input  trap_pkg::xcpt_t       xcpt_i,

    // Interrupt setup from the register block
    input  csr_pkg::csr_word_t    mie_i,
    input  csr_pkg::csr_word_t    mip_i,
    input  csr_pkg::csr_word_t    mtvec_i,

    // Return PC saved on trap entry
    input  csr_pkg::csr_word_t    nxt_pc_i,

    // System jump strobe, mret_i qualifies it
    input  logic                  sys_jump_i,
    input  logic                  mret_i,

    output logic                  irq_taken_o,
    output csr_pkg::csr_word_t    pc_handler_o,
    output logic                  sys_jump_o,
    output csr_pkg::csr_word_t    sys_jump_pc_o,
    output trap_pkg::trap_state_t trap_state_o,
    output csr_pkg::csr_word_t    mtval_o,
    output trap_pkg::priv_e       priv_o
);

    import csr_pkg::*;
    import trap_pkg::*;

    status_u   status_q;
    csr_word_t mepc_q;
    csr_word_t mcause_q;
    csr_word_t mtval_q;
    priv_e     priv_q;

    // Trap decision for this cycle
    logic      trap_take;
    logic      trap_is_irq;
    logic [3:0] trap_cause;
    csr_word_t irq_pend;
    csr_word_t mcause_d;
    csr_word_t tvec_base;
    logic      do_mret;

    // ------------------------------------------------------------------------
    // Trap selection
    // ------------------------------------------------------------------------

    // Mask again so a cleared enable acts before mip catches up
    assign irq_pend = mip_i & mie_i;

    always_comb
    begin
        trap_take   = 1'b0;
        trap_is_irq = 1'b0;
        trap_cause  = 4'd0;
        if (xcpt_i.valid)
        begin
            // Exceptions are taken in any mode
            trap_take  = 1'b1;
            trap_cause = xcpt_i.cause;
        end
        else if ((priv_q == PRIV_M) && status_q.f.mie)
        begin
            // Fixed priority, external then timer then software
            if (irq_pend[IRQ_MEI])
            begin
                trap_take   = 1'b1;
                trap_is_irq = 1'b1;
                trap_cause  = IRQ_MEI;
            end
            else if (irq_pend[IRQ_MTI])
            begin
                trap_take   = 1'b1;
                trap_is_irq = 1'b1;
                trap_cause  = IRQ_MTI;
            end
            else if (irq_pend[IRQ_MSI])
            begin
                trap_take   = 1'b1;
                trap_is_irq = 1'b1;
                trap_cause  = IRQ_MSI;
            end
        end
    end

    // Interrupt flag in bit 31, code in the low bits
    assign mcause_d = {trap_is_irq, 27'd0, trap_cause};

    // Handler address, vectored mode only offsets interrupts
    assign tvec_base = {mtvec_i[31:2], 2'b00};

    always_comb
    begin
        if (trap_is_irq && (mtvec_i[1:0] == 2'b01))
        begin
            pc_handler_o = tvec_base + {26'd0, trap_cause, 2'b00};
        end
        else
        begin
            pc_handler_o = tvec_base;
        end
    end

    assign do_mret = sys_jump_i && mret_i;

    // ------------------------------------------------------------------------
    // Trap registers
    // ------------------------------------------------------------------------

    // Order at an edge is trap entry, then mret, then CSR write
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            // MPP machine and MIE set
            status_q.raw <= 32'h0000_1808;
        end
        else if (trap_take)
        begin
            status_q.f.mpie <= status_q.f.mie;
            status_q.f.mie  <= 1'b0;
            status_q.f.mpp  <= priv_q;
        end
        else if (do_mret)
        begin
            status_q.f.mie  <= status_q.f.mpie;
            status_q.f.mpie <= 1'b1;
        end
        else if (csr_wr_i.we && (csr_wr_i.addr == CSR_MSTATUS))
        begin
            status_q.raw <= csr_wr_i.data;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end
        else if (trap_take)
        begin
            mepc_q   <= nxt_pc_i;
            mcause_q <= mcause_d;
            // Only some exceptions carry a trap value
            if (xcpt_i.valid && XCPT_TVAL_SET[xcpt_i.cause])
            begin
                mtval_q <= xcpt_i.tval;
            end
        end
        else if (csr_wr_i.we && !do_mret)
        begin
            case (csr_wr_i.addr)
                CSR_MEPC:   mepc_q   <= csr_wr_i.data;
                CSR_MCAUSE: mcause_q <= csr_wr_i.data;
                CSR_MTVAL:  mtval_q  <= csr_wr_i.data;
                default:    ;
            endcase
        end
    end

    // Privilege, MPP values other than user return to machine
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            priv_q <= PRIV_M;
        end
        else if (trap_take)
        begin
            priv_q <= PRIV_M;
        end
        else if (do_mret)
        begin
            priv_q <= (status_q.f.mpp == PRIV_U) ? PRIV_U : PRIV_M;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    always_comb
    begin
        trap_state_o.priv   = priv_q;
        trap_state_o.status = status_q;
        trap_state_o.mepc   = mepc_q;
        trap_state_o.mcause = mcause_q;
    end

    assign irq_taken_o   = trap_take;
    assign sys_jump_o    = sys_jump_i;
    assign sys_jump_pc_o = mepc_q;
    assign mtval_o       = mtval_q;
    assign priv_o        = priv_q;

endmodule

// ==== trap_pkg.sv ====
package trap_pkg;

    // ------------------------------------------------------------------------
    // Privilege levels
    // ------------------------------------------------------------------------

    // Only user and machine mode exist on this core
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    // ------------------------------------------------------------------------
    // Cause codes
    // ------------------------------------------------------------------------

    // Machine interrupt causes, also the bit positions in mie and mip
    localparam logic [3:0] IRQ_MSI = 4'd3;
    localparam logic [3:0] IRQ_MTI = 4'd7;
    localparam logic [3:0] IRQ_MEI = 4'd11;

    // One bit per exception cause that carries a trap value
    // Causes 0, 1, 4 to 7, 12, 13 and 15
    localparam logic [15:0] XCPT_TVAL_SET = 16'hB0F3;

    // ------------------------------------------------------------------------
    // mstatus layout
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [18:0] rsv_hi;
        // Previous privilege, restored on mret
        logic [1:0]  mpp;
        logic [2:0]  rsv_mid;
        // Interrupt enable saved on trap entry
        logic        mpie;
        logic [2:0]  rsv_lo;
        // Global machine interrupt enable
        logic        mie;
        logic [2:0]  rsv_0;
    } status_fields_t;

    // Writes arrive as a raw word, trap entry and mret use the fields
    typedef union packed {
        status_fields_t      f;
        csr_pkg::csr_word_t  raw;
    } status_u;

    // ------------------------------------------------------------------------
    // Exception request and trap state
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic               valid;
        logic [3:0]         cause;
        csr_pkg::csr_word_t tval;
    } xcpt_t;

    // Trap registers seen by the read multiplexer
    typedef struct packed {
        priv_e              priv;
        status_u            status;
        csr_pkg::csr_word_t mepc;
        csr_pkg::csr_word_t mcause;
    } trap_state_t;

endpackage
